//--- source/ahb_bridge_params.svh
`ifndef AHB_BRIDGE_PARAMS_SVH
`define AHB_BRIDGE_PARAMS_SVH

// Bus and data widths.
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Request queue depth as a power of two.
`define REQ_FIFO_DEPTH 4

// HTRANS encodings.
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// HSIZE encodings.
`define HSIZE_BYTE 3'b000
`define HSIZE_HALF 3'b001
`define HSIZE_WORD 3'b010

`endif

//--- source/ahb_bridge_pkg.sv
`include "ahb_bridge_params.svh"

package ahb_bridge_pkg;

  // *************************************************************************
  // Basic vector types.
  // *************************************************************************

  typedef logic [`AHB_ADDR_W-1:0]   addr_t;
  typedef logic [`AHB_DATA_W-1:0]   data_t;
  typedef logic [`AHB_DATA_W/8-1:0] strb_t;

  // Requesting port.
  typedef logic src_t;

  localparam src_t SRC_INSTR = 1'b0;
  localparam src_t SRC_DATA  = 1'b1;

  // *************************************************************************
  // Request and response records.
  // *************************************************************************

  // A zero strobe field is a read.
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    src_t  src;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
    src_t  src;
  } mem_rsp_t;

  // Data phase tracking in the bus master.
  typedef enum logic [1:0] {
    DP_IDLE,
    DP_ACTIVE,
    DP_ERROR
  } dphase_e;

endpackage

//--- source/mem_port_arbiter.sv
`timescale 1ns/1ps

module mem_port_arbiter (
  input  logic                     m_ahb_hclk,
  input  logic                     m_ahb_hresetn,
  // Core request ports.
  input  ahb_bridge_pkg::mem_req_t instr_req,
  input  logic                     instr_valid,
  output logic                     instr_ready,
  input  ahb_bridge_pkg::mem_req_t data_req,
  input  logic                     data_valid,
  output logic                     data_ready,
  // Merged request stream.
  output ahb_bridge_pkg::mem_req_t arb_req,
  output logic                     arb_valid,
  input  logic                     arb_ready,
  // Responses from the master.
  input  ahb_bridge_pkg::mem_rsp_t rsp,
  input  logic                     rsp_valid,
  // Core response ports.
  output ahb_bridge_pkg::mem_rsp_t instr_rsp,
  output logic                     instr_rsp_valid,
  output ahb_bridge_pkg::mem_rsp_t data_rsp,
  output logic                     data_rsp_valid
);
  import ahb_bridge_pkg::*;

  src_t     last_src;
  logic     slot_valid;
  mem_req_t slot_req;
  logic     slot_free;
  logic     instr_take;
  logic     data_take;
  mem_req_t grant_req;

  // The slot can load when empty or when it drains this cycle.
  assign slot_free = !slot_valid || arb_ready;

  // On contention the port that was not granted last wins.
  assign instr_ready = slot_free && (!data_valid || last_src == SRC_DATA);
  assign data_ready  = slot_free && (!instr_valid || last_src == SRC_INSTR);

  assign instr_take = instr_valid && instr_ready;
  assign data_take  = data_valid && data_ready;

  always_comb begin
    grant_req     = data_req;
    grant_req.src = SRC_DATA;
    if (instr_take) begin
      grant_req     = instr_req;
      grant_req.src = SRC_INSTR;
    end
  end

  always_ff @(posedge m_ahb_hclk) begin
    if (!m_ahb_hresetn) begin
      slot_valid <= 1'b0;
      last_src   <= SRC_DATA;
    end else if (instr_take || data_take) begin
      slot_valid <= 1'b1;
      last_src   <= grant_req.src;
    end else if (arb_ready) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge m_ahb_hclk) begin
    if (instr_take || data_take) begin
      slot_req <= grant_req;
    end
  end

  assign arb_req   = slot_req;
  assign arb_valid = slot_valid;

  // *************************************************************************
  // Response steering by source.
  // *************************************************************************

  assign instr_rsp       = rsp;
  assign data_rsp        = rsp;
  assign instr_rsp_valid = rsp_valid && (rsp.src == SRC_INSTR);
  assign data_rsp_valid  = rsp_valid && (rsp.src == SRC_DATA);

  // A stalled request holds until the queue takes it.
  a_slot_stable: assert property (
    @(posedge m_ahb_hclk) disable iff (!m_ahb_hresetn)
    arb_valid && !arb_ready |=> arb_valid && $stable(arb_req)
  );

endmodule

//--- source/req_fifo.sv
`timescale 1ns/1ps

`include "ahb_bridge_params.svh"

module req_fifo #(
  parameter int DEPTH = `REQ_FIFO_DEPTH
) (
  input  logic                     m_ahb_hclk,
  input  logic                     m_ahb_hresetn,
  input  ahb_bridge_pkg::mem_req_t in_req,
  input  logic                     in_valid,
  output logic                     in_ready,
  output ahb_bridge_pkg::mem_req_t out_req,
  output logic                     out_valid,
  input  logic                     out_ready
);
  import ahb_bridge_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  mem_req_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_req   = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Pointers wrap naturally on a power of two depth.
  always_ff @(posedge m_ahb_hclk) begin
    if (!m_ahb_hresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge m_ahb_hclk) begin
    if (push) begin
      mem[wr_ptr] <= in_req;
    end
  end

  // A full queue only leaves the full state through a pop.
  a_no_push_full: assert property (
    @(posedge m_ahb_hclk) disable iff (!m_ahb_hresetn)
    (count == CNT_W'(DEPTH)) && !pop |=> (count == CNT_W'(DEPTH)) && (wr_ptr == rd_ptr)
  );

  // An empty queue only leaves the empty state through a push.
  a_no_pop_empty: assert property (
    @(posedge m_ahb_hclk) disable iff (!m_ahb_hresetn)
    (count == '0) && !push |=> (count == '0) && (rd_ptr == wr_ptr)
  );

endmodule

//--- source/ahb_master.sv
`timescale 1ns/1ps

`include "ahb_bridge_params.svh"

module ahb_master (
  input  logic                     m_ahb_hclk,
  input  logic                     m_ahb_hresetn,
  // Request queue head.
  input  ahb_bridge_pkg::mem_req_t req,
  input  logic                     req_valid,
  output logic                     req_ready,
  // Responses.
  output ahb_bridge_pkg::mem_rsp_t rsp,
  output logic                     rsp_valid,
  // AHB-Lite master port.
  output ahb_bridge_pkg::addr_t    m_ahb_haddr,
  output logic                     m_ahb_hwrite,
  output logic [2:0]               m_ahb_hsize,
  output logic [1:0]               m_ahb_htrans,
  output logic [3:0]               m_ahb_hprot,
  output ahb_bridge_pkg::data_t    m_ahb_hwdata,
  input  ahb_bridge_pkg::data_t    m_ahb_hrdata,
  input  logic                     m_ahb_hready,
  input  logic                     m_ahb_hresp
);
  import ahb_bridge_pkg::*;

  dphase_e    dp_state;
  logic       addr_nonseq;
  logic       addr_accept;
  logic [1:0] addr_low;
  logic [2:0] size;
  data_t      wdata_q;
  src_t       src_q;
  logic [4:0] rd_shift;

  // *************************************************************************
  // Address phase driven straight from the queue head.
  // *************************************************************************

  // Size and lane offset from the strobe pattern.
  always_comb begin
    addr_low = 2'b00;
    size     = `HSIZE_WORD;
    case (req.wstrb)
      4'b0001: begin
        size = `HSIZE_BYTE;
      end
      4'b0010: begin
        size     = `HSIZE_BYTE;
        addr_low = 2'b01;
      end
      4'b0100: begin
        size     = `HSIZE_BYTE;
        addr_low = 2'b10;
      end
      4'b1000: begin
        size     = `HSIZE_BYTE;
        addr_low = 2'b11;
      end
      4'b0011: begin
        size = `HSIZE_HALF;
      end
      4'b1100: begin
        size     = `HSIZE_HALF;
        addr_low = 2'b10;
      end
      default: begin
        size = `HSIZE_WORD;
      end
    endcase
  end

  // No new transfer while an error response is finishing.
  assign addr_nonseq = req_valid && (dp_state != DP_ERROR);
  assign addr_accept = addr_nonseq && m_ahb_hready;
  assign req_ready   = addr_accept;

  assign m_ahb_haddr  = {req.addr[$bits(addr_t)-1:2], addr_low};
  assign m_ahb_hwrite = |req.wstrb;
  assign m_ahb_hsize  = size;
  assign m_ahb_htrans = addr_nonseq ? `HTRANS_NONSEQ : `HTRANS_IDLE;
  assign m_ahb_hprot  = {3'b000, req.src};
  assign m_ahb_hwdata = wdata_q;

  // *************************************************************************
  // Data phase.
  // *************************************************************************

  always_ff @(posedge m_ahb_hclk) begin
    if (!m_ahb_hresetn) begin
      dp_state  <= DP_IDLE;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (dp_state)
        DP_IDLE: begin
          if (addr_accept) begin
            dp_state <= DP_ACTIVE;
          end
        end
        DP_ACTIVE: begin
          if (m_ahb_hready) begin
            rsp_valid <= 1'b1;
            dp_state  <= addr_accept ? DP_ACTIVE : DP_IDLE;
          end else if (m_ahb_hresp) begin
            dp_state <= DP_ERROR;
          end
        end
        DP_ERROR: begin
          if (m_ahb_hready) begin
            rsp_valid <= 1'b1;
            dp_state  <= DP_IDLE;
          end
        end
        default: begin
          dp_state <= DP_IDLE;
        end
      endcase
    end
  end

  // Old src and shift are still in place when the response is captured.
  always_ff @(posedge m_ahb_hclk) begin
    if (addr_accept) begin
      wdata_q  <= req.wdata;
      src_q    <= req.src;
      rd_shift <= {addr_low, 3'b000};
    end
    if (m_ahb_hready && (dp_state != DP_IDLE)) begin
      rsp.rdata <= m_ahb_hrdata >> rd_shift;
      rsp.err   <= (dp_state == DP_ERROR) || m_ahb_hresp;
      rsp.src   <= src_q;
    end
  end

  a_strb_legal: assert property (
    @(posedge m_ahb_hclk) disable iff (!m_ahb_hresetn)
    req_valid |-> req.wstrb inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                    4'b0011, 4'b1100, 4'b1111}
  );

  // The address phase pending behind an error is cancelled and the error comes back.
  a_err_cancel: assert property (
    @(posedge m_ahb_hclk) disable iff (!m_ahb_hresetn)
    (dp_state == DP_ACTIVE) && m_ahb_hresp && !m_ahb_hready
      |=> (m_ahb_htrans == `HTRANS_IDLE) ##1 rsp_valid && rsp.err
  );

endmodule

//--- source/ahb_bridge_top.sv
`timescale 1ns/1ps

`include "ahb_bridge_params.svh"

module ahb_bridge_top (
  input  logic                     m_ahb_hclk,
  input  logic                     m_ahb_hresetn,
  // Instruction port.
  input  ahb_bridge_pkg::mem_req_t instr_req,
  input  logic                     instr_valid,
  output logic                     instr_ready,
  output ahb_bridge_pkg::mem_rsp_t instr_rsp,
  output logic                     instr_rsp_valid,
  // Data port.
  input  ahb_bridge_pkg::mem_req_t data_req,
  input  logic                     data_valid,
  output logic                     data_ready,
  output ahb_bridge_pkg::mem_rsp_t data_rsp,
  output logic                     data_rsp_valid,
  // AHB-Lite bus.
  output ahb_bridge_pkg::addr_t    m_ahb_haddr,
  output logic                     m_ahb_hwrite,
  output logic [2:0]               m_ahb_hsize,
  output logic [1:0]               m_ahb_htrans,
  output logic [3:0]               m_ahb_hprot,
  output ahb_bridge_pkg::data_t    m_ahb_hwdata,
  input  ahb_bridge_pkg::data_t    m_ahb_hrdata,
  input  logic                     m_ahb_hready,
  input  logic                     m_ahb_hresp
);
  import ahb_bridge_pkg::*;

  mem_req_t arb_req;
  logic     arb_valid;
  logic     arb_ready;
  mem_req_t fifo_req;
  logic     fifo_valid;
  logic     fifo_ready;
  mem_rsp_t rsp;
  logic     rsp_valid;

  mem_port_arbiter u_arbiter (
    .m_ahb_hclk      (m_ahb_hclk),
    .m_ahb_hresetn   (m_ahb_hresetn),
    .instr_req       (instr_req),
    .instr_valid     (instr_valid),
    .instr_ready     (instr_ready),
    .data_req        (data_req),
    .data_valid      (data_valid),
    .data_ready      (data_ready),
    .arb_req         (arb_req),
    .arb_valid       (arb_valid),
    .arb_ready       (arb_ready),
    .rsp             (rsp),
    .rsp_valid       (rsp_valid),
    .instr_rsp       (instr_rsp),
    .instr_rsp_valid (instr_rsp_valid),
    .data_rsp        (data_rsp),
    .data_rsp_valid  (data_rsp_valid)
  );

  req_fifo #(
    .DEPTH (`REQ_FIFO_DEPTH)
  ) u_req_fifo (
    .m_ahb_hclk    (m_ahb_hclk),
    .m_ahb_hresetn (m_ahb_hresetn),
    .in_req        (arb_req),
    .in_valid      (arb_valid),
    .in_ready      (arb_ready),
    .out_req       (fifo_req),
    .out_valid     (fifo_valid),
    .out_ready     (fifo_ready)
  );

  ahb_master u_master (
    .m_ahb_hclk    (m_ahb_hclk),
    .m_ahb_hresetn (m_ahb_hresetn),
    .req           (fifo_req),
    .req_valid     (fifo_valid),
    .req_ready     (fifo_ready),
    .rsp           (rsp),
    .rsp_valid     (rsp_valid),
    .m_ahb_haddr   (m_ahb_haddr),
    .m_ahb_hwrite  (m_ahb_hwrite),
    .m_ahb_hsize   (m_ahb_hsize),
    .m_ahb_htrans  (m_ahb_htrans),
    .m_ahb_hprot   (m_ahb_hprot),
    .m_ahb_hwdata  (m_ahb_hwdata),
    .m_ahb_hrdata  (m_ahb_hrdata),
    .m_ahb_hready  (m_ahb_hready),
    .m_ahb_hresp   (m_ahb_hresp)
  );

endmodule

//--- sim/ahb_slave_model.sv
`timescale 1ns/1ps

`include "ahb_bridge_params.svh"

module ahb_slave_model (
  input  logic                  m_ahb_hclk,
  input  logic                  m_ahb_hresetn,
  input  ahb_bridge_pkg::addr_t m_ahb_haddr,
  input  logic                  m_ahb_hwrite,
  input  logic [2:0]            m_ahb_hsize,
  input  logic [1:0]            m_ahb_htrans,
  input  ahb_bridge_pkg::data_t m_ahb_hwdata,
  output ahb_bridge_pkg::data_t m_ahb_hrdata,
  output logic                  m_ahb_hready,
  output logic                  m_ahb_hresp,
  input  logic                  wait_en
);
  import ahb_bridge_pkg::*;

  data_t      mem [256];
  logic       dp_valid;
  addr_t      dp_addr;
  logic       dp_write;
  logic [2:0] dp_size;
  logic [1:0] wait_cnt;
  logic       err_second;
  logic       dp_err;
  logic       dp_done;

  // Fill pattern built from the whole word index.
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end
  end

  // Bit 12 marks the error region.
  assign dp_err       = dp_valid && dp_addr[12];
  assign dp_done      = dp_valid && !dp_err && (wait_cnt == 2'd0);
  assign m_ahb_hready = !dp_valid || dp_done || (dp_err && err_second);
  assign m_ahb_hresp  = dp_err;
  assign m_ahb_hrdata = mem[dp_addr[9:2]];

  always @(posedge m_ahb_hclk) begin
    if (!m_ahb_hresetn) begin
      dp_valid   <= 1'b0;
      wait_cnt   <= 2'd0;
      err_second <= 1'b0;
    end else begin
      if (dp_valid && !m_ahb_hready) begin
        if (dp_err) begin
          err_second <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt - 1'b1;
        end
      end
      // Write merge by size and lane.
      if (dp_done && dp_write) begin
        case (dp_size)
          `HSIZE_BYTE: begin
            mem[dp_addr[9:2]][8*dp_addr[1:0] +: 8] <= m_ahb_hwdata[8*dp_addr[1:0] +: 8];
          end
          `HSIZE_HALF: begin
            mem[dp_addr[9:2]][16*dp_addr[1] +: 16] <= m_ahb_hwdata[16*dp_addr[1] +: 16];
          end
          default: begin
            mem[dp_addr[9:2]] <= m_ahb_hwdata;
          end
        endcase
      end
      // Next address phase.
      if (m_ahb_hready) begin
        dp_valid   <= (m_ahb_htrans == `HTRANS_NONSEQ);
        dp_addr    <= m_ahb_haddr;
        dp_write   <= m_ahb_hwrite;
        dp_size    <= m_ahb_hsize;
        wait_cnt   <= wait_en ? 2'($urandom % 4) : 2'd0;
        err_second <= 1'b0;
      end
    end
  end

endmodule

//--- sim/tb_ahb_bridge.sv
`timescale 1ns/1ps

`include "ahb_bridge_params.svh"

module tb_ahb_bridge;
  import ahb_bridge_pkg::*;

  localparam int CYCLE_LIMIT = 4000;

  typedef struct packed {
    mem_rsp_t rsp;
    logic     is_read;
  } exp_rsp_t;

  typedef struct packed {
    addr_t      haddr;
    logic       hwrite;
    logic [2:0] hsize;
    logic       hprot0;
  } bus_phase_t;

  logic       m_ahb_hclk;
  logic       m_ahb_hresetn;
  mem_req_t   instr_req;
  logic       instr_valid;
  logic       instr_ready;
  mem_rsp_t   instr_rsp;
  logic       instr_rsp_valid;
  mem_req_t   data_req;
  logic       data_valid;
  logic       data_ready;
  mem_rsp_t   data_rsp;
  logic       data_rsp_valid;
  addr_t      haddr;
  logic       hwrite;
  logic [2:0] hsize;
  logic [1:0] htrans;
  logic [3:0] hprot;
  data_t      hwdata;
  data_t      hrdata;
  logic       hready;
  logic       hresp;
  logic       wait_en;

  data_t      shadow [256];
  strb_t      strb_set [7];
  exp_rsp_t   instr_exp [$];
  exp_rsp_t   data_exp [$];
  bus_phase_t instr_bus [$];
  bus_phase_t data_bus [$];
  int         req_count [2];
  int         rsp_count [2];
  int         full_cycles;
  int         cycle_count = 0;

  initial begin
    m_ahb_hclk = 1'b0;
    forever #50 m_ahb_hclk = ~m_ahb_hclk;
  end

  ahb_bridge_top dut (
    .m_ahb_hclk      (m_ahb_hclk),
    .m_ahb_hresetn   (m_ahb_hresetn),
    .instr_req       (instr_req),
    .instr_valid     (instr_valid),
    .instr_ready     (instr_ready),
    .instr_rsp       (instr_rsp),
    .instr_rsp_valid (instr_rsp_valid),
    .data_req        (data_req),
    .data_valid      (data_valid),
    .data_ready      (data_ready),
    .data_rsp        (data_rsp),
    .data_rsp_valid  (data_rsp_valid),
    .m_ahb_haddr     (haddr),
    .m_ahb_hwrite    (hwrite),
    .m_ahb_hsize     (hsize),
    .m_ahb_htrans    (htrans),
    .m_ahb_hprot     (hprot),
    .m_ahb_hwdata    (hwdata),
    .m_ahb_hrdata    (hrdata),
    .m_ahb_hready    (hready),
    .m_ahb_hresp     (hresp)
  );

  ahb_slave_model slave (
    .m_ahb_hclk    (m_ahb_hclk),
    .m_ahb_hresetn (m_ahb_hresetn),
    .m_ahb_haddr   (haddr),
    .m_ahb_hwrite  (hwrite),
    .m_ahb_hsize   (hsize),
    .m_ahb_htrans  (htrans),
    .m_ahb_hwdata  (hwdata),
    .m_ahb_hrdata  (hrdata),
    .m_ahb_hready  (hready),
    .m_ahb_hresp   (hresp),
    .wait_en       (wait_en)
  );

  // ************************************************************************
  // Failure reporting and compare tasks.
  // ************************************************************************

  task automatic report_failure();
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rsp(input string name, input mem_rsp_t want, input mem_rsp_t got);
    if (got.err !== want.err || got.src !== want.src) begin
      $display("CHECK FAILED time=%0t %s: expected err=%b src=%b, got err=%b src=%b",
               $time, name, want.err, want.src, got.err, got.src);
      report_failure();
    end
  endtask

  task automatic check_data(input string name, input data_t want, input data_t got);
    if (got !== want) begin
      $display("CHECK FAILED time=%0t %s: expected %h, got %h", $time, name, want, got);
      report_failure();
    end
  endtask

  task automatic check_bus(input string name, input bus_phase_t want, input bus_phase_t got);
    if (got !== want) begin
      $display("CHECK FAILED time=%0t %s: expected addr=%h write=%b size=%0d prot0=%b",
               $time, name, want.haddr, want.hwrite, want.hsize, want.hprot0);
      $display("  got addr=%h write=%b size=%0d prot0=%b",
               got.haddr, got.hwrite, got.hsize, got.hprot0);
      report_failure();
    end
  endtask

  task automatic check_ctrl(input string name, input logic [1:0] want, input logic [1:0] got);
    if (got !== want) begin
      $display("CHECK FAILED time=%0t %s: expected %b, got %b", $time, name, want, got);
      report_failure();
    end
  endtask

  // ************************************************************************
  // Prediction.
  // ************************************************************************

  function automatic data_t initial_word(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a, ~a, a ^ 8'h5a, 8'hc3};
  endfunction

  // One strobe is a byte, two are a half-word, none or all a word.
  function automatic bus_phase_t expect_phase(input mem_req_t req, input src_t port);
    bus_phase_t ph;
    int         ones;
    int         lane;
    ones = 0;
    lane = 0;
    for (int i = 3; i >= 0; i--) begin
      if (req.wstrb[i]) begin
        ones++;
        lane = i;
      end
    end
    ph.haddr  = {req.addr[31:2], 2'b00};
    ph.hsize  = `HSIZE_WORD;
    if (ones == 1 || ones == 2) begin
      ph.hsize       = (ones == 1) ? `HSIZE_BYTE : `HSIZE_HALF;
      ph.haddr[1:0]  = 2'(lane);
    end
    ph.hwrite = (ones != 0);
    ph.hprot0 = port;
    return ph;
  endfunction

  // ************************************************************************
  // Stimulus.
  // ************************************************************************

  // Starts at a rising edge and returns at the edge that took the request.
  task automatic send_req(input src_t port, input addr_t addr, input data_t wdata,
                          input strb_t strb);
    mem_req_t req;
    exp_rsp_t pred;
    logic     ready_seen;
    req.addr      = addr;
    req.wdata     = wdata;
    req.wstrb     = strb;
    req.src       = 1'b0;
    pred.rsp.rdata = shadow[addr[9:2]];
    pred.rsp.err   = addr[12];
    pred.rsp.src   = port;
    pred.is_read   = (strb == '0);
    if (!addr[12]) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          shadow[addr[9:2]][8*i +: 8] = wdata[8*i +: 8];
        end
      end
    end
    req_count[port]++;
    if (port == SRC_INSTR) begin
      instr_exp.push_back(pred);
      instr_bus.push_back(expect_phase(req, port));
      instr_req   <= req;
      instr_valid <= 1'b1;
    end else begin
      data_exp.push_back(pred);
      data_bus.push_back(expect_phase(req, port));
      data_req   <= req;
      data_valid <= 1'b1;
    end
    ready_seen = 1'b0;
    while (!ready_seen) begin
      @(negedge m_ahb_hclk);
      ready_seen = (port == SRC_INSTR) ? instr_ready : data_ready;
      @(posedge m_ahb_hclk);
    end
  endtask

  task automatic idle_port(input src_t port);
    if (port == SRC_INSTR) begin
      instr_valid <= 1'b0;
    end else begin
      data_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    while (instr_exp.size() != 0 || data_exp.size() != 0) begin
      @(negedge m_ahb_hclk);
    end
    if (instr_bus.size() != 0 || data_bus.size() != 0) begin
      $display("A request never showed an address phase on the bus");
      report_failure();
    end
    @(posedge m_ahb_hclk);
  endtask

  task automatic check_counts();
    // Quiet window so that a stray or repeated response still shows up.
    repeat (16) @(posedge m_ahb_hclk);
    for (int p = 0; p < 2; p++) begin
      if (req_count[p] != rsp_count[p]) begin
        $display("Port %0d issued %0d requests but got %0d responses",
                 p, req_count[p], rsp_count[p]);
        report_failure();
      end
    end
  endtask

  // ************************************************************************
  // Monitor.
  // ************************************************************************

  task automatic take_rsp(input src_t port, input mem_rsp_t got);
    exp_rsp_t want;
    string    name;
    name = (port == SRC_INSTR) ? "instr_rsp" : "data_rsp";
    if ((port == SRC_INSTR) ? (instr_exp.size() == 0) : (data_exp.size() == 0)) begin
      $display("Response on %s with no request outstanding on that port", name);
      report_failure();
    end else begin
      if (port == SRC_INSTR) begin
        want = instr_exp.pop_front();
      end else begin
        want = data_exp.pop_front();
      end
      check_rsp(name, want.rsp, got);
      if (want.is_read && !want.rsp.err) begin
        check_data({name, ".rdata"}, want.rsp.rdata, got.rdata);
      end
    end
  endtask

  task automatic take_phase();
    bus_phase_t got;
    bus_phase_t want;
    got.haddr  = haddr;
    got.hwrite = hwrite;
    got.hsize  = hsize;
    got.hprot0 = hprot[0];
    if ((hprot[0] == SRC_INSTR) ? (instr_bus.size() == 0) : (data_bus.size() == 0)) begin
      $display("Address phase with hprot[0]=%b but no request pending on that port", hprot[0]);
      report_failure();
    end else begin
      if (hprot[0] == SRC_INSTR) begin
        want = instr_bus.pop_front();
      end else begin
        want = data_bus.pop_front();
      end
      check_bus("m_ahb_haddr/hwrite/hsize/hprot", want, got);
    end
  endtask

  always @(negedge m_ahb_hclk) begin
    if (m_ahb_hresetn) begin
      if (instr_rsp_valid) begin
        rsp_count[SRC_INSTR]++;
        take_rsp(SRC_INSTR, instr_rsp);
      end
      if (data_rsp_valid) begin
        rsp_count[SRC_DATA]++;
        take_rsp(SRC_DATA, data_rsp);
      end
      if (htrans == `HTRANS_NONSEQ && hready) begin
        take_phase();
      end
      // Both readies low with both valids high means the queue is full.
      if (instr_valid && data_valid && !instr_ready && !data_ready) begin
        full_cycles++;
      end
    end
  end

  always @(posedge m_ahb_hclk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", CYCLE_LIMIT);
      report_failure();
    end
  end

  // ************************************************************************
  // Directed tests.
  // ************************************************************************

  task automatic check_idle_state();
    check_ctrl("m_ahb_htrans", `HTRANS_IDLE, htrans);
    check_ctrl("instr_rsp_valid", 2'b00, {1'b0, instr_rsp_valid});
    check_ctrl("data_rsp_valid", 2'b00, {1'b0, data_rsp_valid});
    check_ctrl("instr_ready", 2'b01, {1'b0, instr_ready});
    check_ctrl("data_ready", 2'b01, {1'b0, data_ready});
  endtask

  task automatic reset_behavior();
    for (int i = 0; i < 11; i++) begin
      @(posedge m_ahb_hclk);
      if (i == 7) begin
        m_ahb_hresetn <= 1'b1;
      end
      @(negedge m_ahb_hclk);
      check_idle_state();
    end
    @(posedge m_ahb_hclk);
  endtask

  task automatic data_write_read();
    for (int i = 0; i < 7; i++) begin
      send_req(SRC_DATA, 32'h100 + 4 * (i % 4), 32'h1357_9bdf ^ (32'h0101_0101 * i),
               strb_set[i]);
    end
    for (int i = 0; i < 4; i++) begin
      send_req(SRC_DATA, 32'h100 + 4 * i, '0, '0);
    end
    idle_port(SRC_DATA);
    wait_drain();
  endtask

  task automatic instr_fetch();
    for (int i = 0; i < 8; i++) begin
      send_req(SRC_INSTR, 32'h0f0 + 8 * i, '0, '0);
    end
    idle_port(SRC_INSTR);
    wait_drain();
  endtask

  task automatic dual_port_mix();
    fork
      begin
        for (int i = 0; i < 12; i++) begin
          send_req(SRC_INSTR, 32'h040 + 4 * i, '0, '0);
        end
        idle_port(SRC_INSTR);
      end
      begin
        for (int i = 0; i < 6; i++) begin
          send_req(SRC_DATA, 32'h200 + 4 * i, $urandom, 4'b1111);
          send_req(SRC_DATA, 32'h200 + 4 * i, '0, '0);
        end
        idle_port(SRC_DATA);
      end
    join
    wait_drain();
    check_counts();
  endtask

  // Error addresses alias the low words through bit 12.
  task automatic error_region();
    send_req(SRC_DATA, 32'h1080, 32'hdead_beef, 4'b1111);
    send_req(SRC_DATA, 32'h1080, '0, '0);
    send_req(SRC_DATA, 32'h0080, '0, '0);
    send_req(SRC_DATA, 32'h1084, 32'h0000_ff00, 4'b0010);
    send_req(SRC_DATA, 32'h0084, '0, '0);
    idle_port(SRC_DATA);
    send_req(SRC_INSTR, 32'h1088, '0, '0);
    idle_port(SRC_INSTR);
    wait_drain();
  endtask

  task automatic backpressure_stream();
    addr_t waddr;
    wait_en     <= 1'b1;
    full_cycles = 0;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          send_req(SRC_INSTR, 32'h000 + 4 * ($urandom % 64), '0, '0);
        end
        idle_port(SRC_INSTR);
      end
      begin
        for (int i = 0; i < 40; i++) begin
          waddr = 32'h300 + 4 * ($urandom % 64);
          if ($urandom % 2) begin
            send_req(SRC_DATA, waddr, $urandom, strb_set[$urandom % 7]);
          end else begin
            send_req(SRC_DATA, waddr, '0, '0);
          end
        end
        idle_port(SRC_DATA);
      end
    join
    wait_drain();
    wait_en <= 1'b0;
    if (full_cycles == 0) begin
      $display("Port readies never dropped while the request FIFO was full");
      report_failure();
    end
    check_counts();
  endtask

  initial begin
    void'($urandom(32'h21ac));
    m_ahb_hresetn = 1'b0;
    instr_req     = '0;
    instr_valid   = 1'b0;
    data_req      = '0;
    data_valid    = 1'b0;
    wait_en       = 1'b0;
    full_cycles   = 0;
    req_count     = '{0, 0};
    rsp_count     = '{0, 0};
    strb_set      = '{4'b1111, 4'b1100, 4'b0010, 4'b1000, 4'b0011, 4'b0001, 4'b0100};
    for (int i = 0; i < 256; i++) begin
      shadow[i] = initial_word(i);
    end

    reset_behavior();
    data_write_read();
    instr_fetch();
    dual_port_mix();
    error_region();
    backpressure_stream();

    $display("No errors");
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/ahb_bridge_pkg.sv
source/mem_port_arbiter.sv
source/req_fifo.sv
source/ahb_master.sv
source/ahb_bridge_top.sv
sim/ahb_slave_model.sv
sim/tb_ahb_bridge.sv

//--- Bender.yml
package:
  name: ahb_bridge

sources:
  - include_dirs:
      - source
    files:
      - source/ahb_bridge_pkg.sv
      - source/mem_port_arbiter.sv
      - source/req_fifo.sv
      - source/ahb_master.sv
      - source/ahb_bridge_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/ahb_slave_model.sv
      - sim/tb_ahb_bridge.sv
